// ==== project.f ====
+incdir+src
src/eboxPkg.sv
src/apr.sv
src/pi.sv
src/ebusMux.sv
src/ebox.sv
verification/eboxTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = eboxTb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/eboxTb.sv ====
`timescale 1ns/100ps
`include "ebox_config.svh"

module eboxTb;
  import eboxPkg::*;

  localparam int clkPeriod = 4;
  // functions sent by the stimulus below: 4 apr, 24 pi, 4 held, 40 random.
  localparam int plannedFuncs = 72;

  logic eboxClk;
  logic arstN;
  logic cmdValid;
  tDiagCmd cmd;
  logic [1:0] cmdCredit;
  logic sbusErr;
  logic nxmErr;
  logic mbParErr;
  logic cshAdrParErr;
  logic [1:`PI_LEVELS] piReq;
  logic ebusCredit;
  logic ebusValid;
  tEbusWord ebusWord;
  logic anyEboxError;
  logic piRequest;
  logic [2:0] piLevel;

  // reference model state.
  logic [0:3] expFlags;
  logic [0:3] expAprEn;
  logic expAnyErr;
  logic [1:`PI_LEVELS] expPiEn;
  logic [1:`PI_LEVELS] expActive;
  logic [2:0] expLevel;
  logic expRetire;
  logic [0:35] expHead;
  int expCount;
  logic [0:35] expQ[$];
  logic [0:3] nextFlags;
  logic [0:3] nextAprEn;
  logic [1:`PI_LEVELS] nextPiEn;
  logic [1:`PI_LEVELS] nextActive;

  int senderCredits;
  int rxPending;
  int sentCount;
  int returnedCount;
  int valueErrors;
  int otherErrors;
  logic holdCredits;
  tDiagFunc lastFunc;
  tDiagFunc randFunc;

  ebox dut0(.*);

  function automatic logic [2:0] firstActive(input logic [1:`PI_LEVELS] levels);
    logic [2:0] result;
    result = 3'd0;
    for (int lvl = 1; lvl <= `PI_LEVELS; lvl++) begin
      if (levels[lvl] && (result == 3'd0)) begin
        result = 3'(lvl);
      end
    end
    return result;
  endfunction

  // ======================================================================
  // reference model, updated on the same edges as the DUT.
  // ======================================================================

  always @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      expFlags <= '0;
      expAprEn <= '0;
      expAnyErr <= 1'b0;
      expPiEn <= '0;
      expActive <= '0;
      expLevel <= 3'd0;
      expRetire <= 1'b0;
      expHead <= '0;
      expCount <= 0;
      expQ.delete();
      senderCredits <= `RESP_FIFO_DEPTH;
      rxPending <= 0;
    end else begin
      nextFlags = expFlags;
      nextAprEn = expAprEn;
      nextPiEn = expPiEn;
      // the word leaving now is the oldest one.
      if (ebusValid && (expQ.size() != 0)) begin
        void'(expQ.pop_front());
      end
      if (cmdValid) begin
        case (cmd.func)
          DIAG_WRITE_APR_EN: nextAprEn = cmd.data[32:35];
          DIAG_CLEAR_APR: nextFlags = expFlags & ~cmd.data[32:35];
          DIAG_WRITE_PI_EN: nextPiEn = cmd.data[29:35];
          DIAG_READ_APR: expQ.push_back({28'd0, expAprEn, expFlags});
          DIAG_READ_PI: expQ.push_back({19'd0, expLevel, expPiEn, expActive});
          default: ;
        endcase
      end
      nextFlags = nextFlags | {sbusErr, nxmErr, mbParErr, cshAdrParErr};
      nextActive = piReq & nextPiEn;
      expFlags <= nextFlags;
      expAprEn <= nextAprEn;
      expAnyErr <= |(nextFlags & nextAprEn);
      expPiEn <= nextPiEn;
      expActive <= nextActive;
      expLevel <= firstActive(nextActive);
      expRetire <= cmdValid && (cmd.func != DIAG_READ_APR) && (cmd.func != DIAG_READ_PI);
      expHead <= (expQ.size() != 0) ? expQ[0] : '0;
      expCount <= expQ.size();
      senderCredits <= senderCredits - int'(cmdValid) + int'(cmdCredit);
      rxPending <= rxPending + int'(ebusValid) - int'(ebusCredit);
      sentCount <= sentCount + int'(cmdValid);
      returnedCount <= returnedCount + int'(cmdCredit);
    end
  end

  // ======================================================================
  // checks.
  // ======================================================================

  resetOutputs: assert property (@(posedge eboxClk)
    !arstN |-> (!ebusValid && (cmdCredit == 2'd0) && !anyEboxError && !piRequest &&
                (piLevel == 3'd0))
  ) else begin
    otherErrors++;
    $display("outputs not at their reset values at %0t", $time);
  end

  anyErrorCheck: assert property (@(posedge eboxClk) disable iff (!arstN)
    anyEboxError == expAnyErr
  ) else begin
    valueErrors++;
    $display("FAILED at %0t: anyEboxError = %b, expected %b", $time,
             $sampled(anyEboxError), $sampled(expAnyErr));
  end

  piLevelCheck: assert property (@(posedge eboxClk) disable iff (!arstN)
    piLevel == expLevel
  ) else begin
    valueErrors++;
    $display("FAILED at %0t: piLevel = %0d, expected %0d", $time,
             $sampled(piLevel), $sampled(expLevel));
  end

  piRequestCheck: assert property (@(posedge eboxClk) disable iff (!arstN)
    piRequest == (|expActive)
  ) else begin
    valueErrors++;
    $display("FAILED at %0t: piRequest = %b, expected %b", $time,
             $sampled(piRequest), $sampled(|expActive));
  end

  wordCheck: assert property (@(posedge eboxClk) disable iff (!arstN)
    ebusValid |-> (ebusWord.data == expHead)
  ) else begin
    valueErrors++;
    $display("FAILED at %0t: ebusWord.data = %h, expected %h", $time,
             $sampled(ebusWord.data), $sampled(expHead));
  end

  // odd parity over data and parity bit.
  parityCheck: assert property (@(posedge eboxClk) disable iff (!arstN)
    ebusValid |-> (^ebusWord == 1'b1)
  ) else begin
    valueErrors++;
    $display("FAILED at %0t: ebusWord.parity = %b, expected %b", $time,
             $sampled(ebusWord.parity), ~$sampled(ebusWord.parity));
  end

  cmdCreditCheck: assert property (@(posedge eboxClk) disable iff (!arstN)
    cmdCredit == (2'(expRetire) + 2'(ebusValid))
  ) else begin
    valueErrors++;
    $display("FAILED at %0t: cmdCredit = %0d, expected %0d", $time,
             $sampled(cmdCredit), $sampled(2'(expRetire) + 2'(ebusValid)));
  end

  unexpectedWord: assert property (@(posedge eboxClk) disable iff (!arstN)
    ebusValid |-> (expCount != 0)
  ) else begin
    otherErrors++;
    $display("a word went out on the EBUS with no read waiting at %0t", $time);
  end

  ebusCreditRespected: assert property (@(posedge eboxClk) disable iff (!arstN)
    ebusValid |-> (rxPending < `EBUS_CREDITS)
  ) else begin
    otherErrors++;
    $display("a word was sent with no EBUS credit left at %0t", $time);
  end

  senderCreditBound: assert property (@(posedge eboxClk) disable iff (!arstN)
    (senderCredits >= 0) && (senderCredits <= `RESP_FIFO_DEPTH)
  ) else begin
    otherErrors++;
    $display("sender credits out of range (%0d) at %0t", $sampled(senderCredits), $time);
  end

  // ======================================================================
  // clock, receiver, watchdog.
  // ======================================================================

  initial begin
    eboxClk = 1'b0;
    forever #(clkPeriod / 2) eboxClk = ~eboxClk;
  end

  // returns one credit per word after a random delay.
  initial begin
    ebusCredit = 1'b0;
    forever begin
      @(negedge eboxClk);
      ebusCredit = !holdCredits && (rxPending > 0) && (($urandom % 3) == 0);
    end
  end

  initial begin
    #((20 * plannedFuncs + 200) * clkPeriod);
    $display("timeout: the run did not finish in time, the DUT seems to hang");
    $display("Test FAILED");
    $finish;
  end

  // ======================================================================
  // stimulus.
  // ======================================================================

  task automatic sendFunc(input tDiagFunc func, input logic [0:35] data);
    while (senderCredits == 0) begin
      @(negedge eboxClk);
    end
    cmdValid = 1'b1;
    cmd = '{func: func, data: data};
    @(negedge eboxClk);
    cmdValid = 1'b0;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) @(negedge eboxClk);
  endtask

  task automatic randomErrors(input int oneIn);
    sbusErr = ($urandom % oneIn) == 0;
    nxmErr = ($urandom % oneIn) == 0;
    mbParErr = ($urandom % oneIn) == 0;
    cshAdrParErr = ($urandom % oneIn) == 0;
  endtask

  initial begin
    void'($urandom(32'h277bbf11));
    arstN = 1'b0;
    cmdValid = 1'b0;
    cmd = '0;
    {sbusErr, nxmErr, mbParErr, cshAdrParErr} = 4'b0000;
    piReq = '0;
    holdCredits = 1'b0;
    sentCount = 0;
    returnedCount = 0;
    valueErrors = 0;
    otherErrors = 0;
    repeat (2) @(negedge eboxClk);
    arstN = 1'b1;
    idleCycles(2);

    // apr flags, enables and a clear racing a new error.
    sendFunc(DIAG_WRITE_APR_EN, {32'd0, 4'b1010});
    for (int i = 0; i < 6; i++) begin
      randomErrors(4);
      idleCycles(1);
    end
    {sbusErr, nxmErr, mbParErr, cshAdrParErr} = 4'b0000;
    sendFunc(DIAG_READ_APR, '0);
    sbusErr = 1'b1;
    sendFunc(DIAG_CLEAR_APR, {32'd0, 4'b1111});
    sbusErr = 1'b0;
    sendFunc(DIAG_READ_APR, '0);

    // pi masks and priority.
    for (int i = 0; i < 12; i++) begin
      piReq = `PI_LEVELS'($urandom);
      sendFunc(DIAG_WRITE_PI_EN, {29'd0, 7'($urandom)});
      idleCycles(2);
      sendFunc(DIAG_READ_PI, '0);
    end

    // hold EBUS credits back, then let them go.
    holdCredits = 1'b1;
    for (int i = 0; i < 4; i++) begin
      sendFunc((i % 2 == 0) ? DIAG_READ_APR : DIAG_READ_PI, '0);
    end
    idleCycles(12);
    holdCredits = 1'b0;

    // apr reads never go out back to back.
    lastFunc = DIAG_NOP;
    for (int i = 0; i < 40; i++) begin
      randomErrors(8);
      piReq = `PI_LEVELS'($urandom);
      randFunc = tDiagFunc'($urandom_range(0, 5));
      if ((randFunc == DIAG_READ_APR) && (lastFunc == DIAG_READ_APR)) begin
        randFunc = DIAG_READ_PI;
      end
      sendFunc(randFunc, {4'($urandom), 32'($urandom)});
      lastFunc = randFunc;
    end
    {sbusErr, nxmErr, mbParErr, cshAdrParErr} = 4'b0000;

    while ((expQ.size() != 0) || (rxPending != 0)) begin
      @(negedge eboxClk);
    end
    idleCycles(2);
    if (sentCount != returnedCount) begin
      otherErrors++;
      $display("%0d functions sent but %0d credits returned", sentCount, returnedCount);
    end
    $display("errors: %0d wrong values, %0d other", valueErrors, otherErrors);
    if ((valueErrors == 0) && (otherErrors == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== src/ebox.sv ====
`timescale 1ns/100ps
`include "ebox_config.svh"

module ebox(
  input logic eboxClk,
  input logic arstN,

  input logic cmdValid,
  input eboxPkg::tDiagCmd cmd,
  output logic [1:0] cmdCredit,

  input logic sbusErr,
  input logic nxmErr,
  input logic mbParErr,
  input logic cshAdrParErr,
  input logic [1:`PI_LEVELS] piReq,

  input logic ebusCredit,
  output logic ebusValid,
  output eboxPkg::tEbusWord ebusWord,

  output logic anyEboxError,
  output logic piRequest,
  output logic [2:0] piLevel
);
  import eboxPkg::*;

  // ======================================================================
  // EBUS sources.
  // ======================================================================

  tEBUSdriver aprDriver;
  tEBUSdriver piDriver;

  apr apr0(.*);
  pi  pi0(.*);

  // ======================================================================
  // merge and delivery.
  // ======================================================================

  ebusMux ebusMux0(.*, .cmdFunc(cmd.func));

endmodule

// ==== src/ebusMux.sv ====
`timescale 1ns/100ps
`include "ebox_config.svh"

module ebusMux(
  input logic eboxClk,
  input logic arstN,
  input eboxPkg::tEBUSdriver aprDriver,
  input eboxPkg::tEBUSdriver piDriver,
  input logic cmdValid,
  input eboxPkg::tDiagFunc cmdFunc,
  input logic ebusCredit,
  output logic ebusValid,
  output eboxPkg::tEbusWord ebusWord,
  output logic [1:0] cmdCredit
);
  import eboxPkg::*;

  localparam int ptrWidth = $clog2(`RESP_FIFO_DEPTH);
  localparam int countWidth = $clog2(`RESP_FIFO_DEPTH + 1);
  localparam int creditWidth = $clog2(`EBUS_CREDITS + 1);

  tEbusWord respQ [`RESP_FIFO_DEPTH];
  tEbusWord pushWord;
  logic [0:35] mergedData;
  logic push;
  logic pop;
  logic retireNow;
  logic retireQ;
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [countWidth-1:0] count;
  logic [creditWidth-1:0] txCredit;

  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
    logic [ptrWidth-1:0] result;
    if (ptr == ptrWidth'(`RESP_FIFO_DEPTH - 1)) begin
      result = '0;
    end else begin
      result = ptr + 1'b1;
    end
    return result;
  endfunction

  // ======================================================================
  // driver merge and parity.
  // ======================================================================

  always_comb begin
    mergedData = '0;
    if (aprDriver.driving) begin
      mergedData = mergedData | aprDriver.data;
    end
    if (piDriver.driving) begin
      mergedData = mergedData | piDriver.data;
    end
  end

  assign push = aprDriver.driving || piDriver.driving;
  assign pushWord = '{data: mergedData, parity: ~^mergedData};

  // ======================================================================
  // response queue and transmit credits.
  // ======================================================================

  assign ebusValid = (count != '0) && (txCredit != '0);
  assign pop = ebusValid;
  assign ebusWord = respQ[rdPtr];

  always_ff @(posedge eboxClk) begin
    if (push) begin
      respQ[wrPtr] <= pushWord;
    end
  end

  // reads retire when their word leaves, everything else right away.
  assign retireNow = cmdValid && (cmdFunc != DIAG_READ_APR) && (cmdFunc != DIAG_READ_PI);
  assign cmdCredit = 2'(retireQ) + 2'(pop);

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      txCredit <= creditWidth'(`EBUS_CREDITS);
      retireQ <= 1'b0;
    end else begin
      retireQ <= retireNow;
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({pop, ebusCredit})
        2'b10: txCredit <= txCredit - 1'b1;
        2'b01: txCredit <= txCredit + 1'b1;
        default: txCredit <= txCredit;
      endcase
    end
  end

  singleDriver: assert property (
    @(posedge eboxClk) disable iff (!arstN)
    !(aprDriver.driving && piDriver.driving)
  ) else $error("apr and pi drove the EBUS together");

  // sender overdrawing its credits ends up here.
  noQueueOverflow: assert property (
    @(posedge eboxClk) disable iff (!arstN)
    push |-> (count != countWidth'(`RESP_FIFO_DEPTH))
  ) else $error("push into a full response queue");

  creditBound: assert property (
    @(posedge eboxClk) disable iff (!arstN)
    txCredit <= creditWidth'(`EBUS_CREDITS)
  ) else $error("EBUS credit count %0d too high", txCredit);

endmodule

// ==== src/pi.sv ====
`timescale 1ns/100ps
`include "ebox_config.svh"

module pi(
  input logic eboxClk,
  input logic arstN,
  input logic cmdValid,
  input eboxPkg::tDiagCmd cmd,
  input logic [1:`PI_LEVELS] piReq,
  output eboxPkg::tEBUSdriver piDriver,
  output logic piRequest,
  output logic [2:0] piLevel
);
  import eboxPkg::*;

  // zero bits above the level field in the read word.
  localparam int padBits = 36 - 3 - 2 * `PI_LEVELS;

  logic [1:`PI_LEVELS] piEnables;
  logic [1:`PI_LEVELS] enablesNext;
  logic [1:`PI_LEVELS] activeLevels;
  logic [1:`PI_LEVELS] activeNext;
  logic [2:0] levelNext;
  logic readPi;
  logic drvActive;
  logic [0:35] drvData;

  // lowest numbered level wins.
  function automatic logic [2:0] lowestLevel(input logic [1:`PI_LEVELS] levels);
    logic [2:0] found;
    found = 3'd0;
    for (int i = `PI_LEVELS; i >= 1; i--) begin
      if (levels[i]) begin
        found = 3'(i);
      end
    end
    return found;
  endfunction

  assign readPi = cmdValid && (cmd.func == DIAG_READ_PI);

  // data bit 29 enables level 1.
  assign enablesNext = (cmdValid && (cmd.func == DIAG_WRITE_PI_EN)) ?
                       cmd.data[36-`PI_LEVELS:35] : piEnables;
  assign activeNext = piReq & enablesNext;
  assign levelNext = lowestLevel(activeNext);

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      piEnables <= '0;
      activeLevels <= '0;
      piLevel <= 3'd0;
      piRequest <= 1'b0;
      drvActive <= 1'b0;
    end else begin
      piEnables <= enablesNext;
      activeLevels <= activeNext;
      piLevel <= levelNext;
      piRequest <= |activeNext;
      drvActive <= readPi;
    end
  end

  // level 19..21, enables 22..28, active 29..35.
  always_ff @(posedge eboxClk) begin
    if (readPi) begin
      drvData <= {padBits'(0), piLevel, piEnables, activeLevels};
    end
  end

  assign piDriver = '{driving: drvActive, data: drvData};

  piRequestMatchesLevel: assert property (
    @(posedge eboxClk) disable iff (!arstN)
    piRequest == (piLevel != 3'd0)
  ) else $error("piRequest disagrees with piLevel %0d", piLevel);

endmodule

// ==== src/apr.sv ====
`timescale 1ns/100ps

module apr(
  input logic eboxClk,
  input logic arstN,
  input logic cmdValid,
  input eboxPkg::tDiagCmd cmd,
  input logic sbusErr,
  input logic nxmErr,
  input logic mbParErr,
  input logic cshAdrParErr,
  output eboxPkg::tEBUSdriver aprDriver,
  output logic anyEboxError
);
  import eboxPkg::*;

  logic [0:3] errIn;
  logic [0:3] errFlags;
  logic [0:3] errEnables;
  logic [0:3] flagsNext;
  logic [0:3] enablesNext;
  logic readApr;
  logic drvActive;
  logic [0:35] drvData;

  // same order as the read word bits 32..35.
  assign errIn = {sbusErr, nxmErr, mbParErr, cshAdrParErr};
  assign readApr = cmdValid && (cmd.func == DIAG_READ_APR);

  always_comb begin
    flagsNext = errFlags;
    enablesNext = errEnables;
    if (cmdValid && (cmd.func == DIAG_WRITE_APR_EN)) begin
      enablesNext = cmd.data[32:35];
    end
    if (cmdValid && (cmd.func == DIAG_CLEAR_APR)) begin
      flagsNext = errFlags & ~cmd.data[32:35];
    end
    // a new error beats a clear.
    flagsNext = flagsNext | errIn;
  end

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      errFlags <= '0;
      errEnables <= '0;
      anyEboxError <= 1'b0;
      drvActive <= 1'b0;
    end else begin
      errFlags <= flagsNext;
      errEnables <= enablesNext;
      anyEboxError <= |(flagsNext & enablesNext);
      drvActive <= readApr;
    end
  end

  // enables in 28..31 and flags in 32..35.
  always_ff @(posedge eboxClk) begin
    if (readApr) begin
      drvData <= {28'd0, errEnables, errFlags};
    end
  end

  assign aprDriver = '{driving: drvActive, data: drvData};

  // one driving cycle per read.
  aprDriveSingleCycle: assert property (
    @(posedge eboxClk) disable iff (!arstN)
    aprDriver.driving |=> !aprDriver.driving
  ) else $error("apr drove the EBUS two cycles in a row");

endmodule

// ==== src/eboxPkg.sv ====
package eboxPkg;

  // ======================================================================
  // diagnostic functions.
  // ======================================================================

  typedef enum logic [2:0] {
    DIAG_NOP          = 3'd0,
    DIAG_READ_APR     = 3'd1,
    DIAG_WRITE_APR_EN = 3'd2,
    DIAG_CLEAR_APR    = 3'd3,
    DIAG_READ_PI      = 3'd4,
    DIAG_WRITE_PI_EN  = 3'd5
  } tDiagFunc;

  typedef struct packed {
    tDiagFunc    func;
    logic [0:35] data;
  } tDiagCmd;

  // ======================================================================
  // EBUS.
  // ======================================================================

  // one per EBUS source.
  typedef struct packed {
    logic        driving;
    logic [0:35] data;
  } tEBUSdriver;

  // parity makes the count of ones odd.
  typedef struct packed {
    logic [0:35] data;
    logic        parity;
  } tEbusWord;

endpackage

// ==== src/ebox_config.svh ====
`ifndef EBOX_CONFIG_SVH
`define EBOX_CONFIG_SVH

// ======================================================================
// response path sizing.
// ======================================================================

// response queue entries and starting sender credits.
`define RESP_FIFO_DEPTH 4

// words the EBUS receiver can hold.
`define EBUS_CREDITS 2

// ======================================================================
// priority interrupts.
// ======================================================================

// levels are numbered 1 up to this.
`define PI_LEVELS 7

`endif
